// File: rtl/realign_src_params.svh
// width macros for the realigning stream source
`ifndef REALIGN_SRC_PARAMS_SVH
`define REALIGN_SRC_PARAMS_SVH

// stream and memory data word
`define RS_DATA_W 32

// byte address of the line start
`define RS_ADDR_W 32

// line length, counted in output words
`define RS_LEN_W 16

// byte offset within a data word
`define RS_OFF_W 2

`endif

// File: rtl/stream_pkg.sv
// stream data-word and byte-offset types
`include "realign_src_params.svh"

package stream_pkg;

  // one stream or memory word, little-endian byte lanes
  typedef logic [`RS_DATA_W-1:0] word_t;

  // byte lane where the line starts in its first word
  typedef logic [`RS_OFF_W-1:0] byte_off_t;

endpackage

// File: rtl/src_cfg_pkg.sv
// config register select, config word union and controller state type
`include "realign_src_params.svh"

package src_cfg_pkg;

  // which config register a write targets
  typedef enum logic {
    CFG_ADDR = 1'b0,
    CFG_GEOM = 1'b1
  } cfg_sel_e;

  // geometry view of a config word
  typedef struct packed {
    logic [`RS_ADDR_W-`RS_LEN_W-1:0] rsvd;
    logic [`RS_LEN_W-1:0]            len;
  } cfg_geom_t;

  // one written word, decoded by cfg_sel_e
  typedef union packed {
    logic [`RS_ADDR_W-1:0] addr;
    cfg_geom_t             geom;
  } cfg_word_u;

  // controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    FLUSH = 2'd2
  } ctrl_state_e;

endpackage

// File: rtl/src_ctrl.sv
// control FSM with config registers, line launch and output word counting
`include "realign_src_params.svh"

module src_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cfg_we_i,
  input  src_cfg_pkg::cfg_sel_e    cfg_sel_i,
  input  src_cfg_pkg::cfg_word_u   cfg_wdata_i,
  input  logic                     start_i,
  input  logic                     out_fire_i,
  output logic                     line_start_o,
  output logic [`RS_ADDR_W-1:0]    base_addr_o,
  output logic [`RS_LEN_W-1:0]     line_len_o,
  output logic                     running_o,
  output logic                     last_word_o,
  output logic                     busy_o,
  output logic                     done_o
);

  src_cfg_pkg::ctrl_state_e state_q, state_d;

  logic [`RS_ADDR_W-1:0] addr_q;
  logic [`RS_LEN_W-1:0]  len_q;
  logic [`RS_LEN_W-1:0]  len_m1;
  logic [`RS_LEN_W-1:0]  word_cnt_q;
  logic                  idle_like;
  logic                  start_ok;

  // FLUSH counts as not busy, so a new line may start there
  assign idle_like = (state_q != src_cfg_pkg::RUN);
  assign start_ok  = start_i && idle_like && (len_q != '0);
  assign len_m1    = len_q - 1'b1;

  // config registers, frozen while a line runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      len_q  <= '0;
    end else if (cfg_we_i && idle_like) begin
      case (cfg_sel_i)
        src_cfg_pkg::CFG_ADDR: addr_q <= cfg_wdata_i.addr;
        src_cfg_pkg::CFG_GEOM: len_q  <= cfg_wdata_i.geom.len;
        default: ;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      src_cfg_pkg::IDLE: begin
        if (start_ok) begin
          state_d = src_cfg_pkg::RUN;
        end
      end
      src_cfg_pkg::RUN: begin
        if (out_fire_i && last_word_o) begin
          state_d = src_cfg_pkg::FLUSH;
        end
      end
      src_cfg_pkg::FLUSH: begin
        state_d = start_ok ? src_cfg_pkg::RUN : src_cfg_pkg::IDLE;
      end
      default: state_d = src_cfg_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= src_cfg_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // output handshakes within the current line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
    end else if (start_ok) begin
      word_cnt_q <= '0;
    end else if (out_fire_i && running_o) begin
      word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  assign line_start_o = start_ok;
  assign base_addr_o  = addr_q;
  assign line_len_o   = len_q;
  assign running_o    = (state_q == src_cfg_pkg::RUN);
  assign last_word_o  = running_o && (word_cnt_q == len_m1);
  assign busy_o       = running_o;
  // one cycle pulse after the last handshake
  assign done_o       = (state_q == src_cfg_pkg::FLUSH);

endmodule

// File: rtl/src_addr_gen.sv
// memory word address generator with first and last fetch flags
`include "realign_src_params.svh"

module src_addr_gen (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           line_start_i,
  input  logic [`RS_ADDR_W-1:0]          base_addr_i,
  input  logic [`RS_LEN_W-1:0]           line_len_i,
  input  logic                           running_i,
  input  logic                           fetch_ready_i,
  input  logic                           mem_gnt_i,
  output logic                           mem_req_o,
  output logic [`RS_ADDR_W-`RS_OFF_W-1:0] mem_addr_o,
  output logic                           fetch_first_o,
  output logic                           fetch_last_o,
  output stream_pkg::byte_off_t          offset_o
);

  logic [`RS_ADDR_W-`RS_OFF_W-1:0] word_addr_q;
  stream_pkg::byte_off_t           offset_q;
  stream_pkg::byte_off_t           start_off;
  // one bit wider than the length, a misaligned line needs N+1 fetches
  logic [`RS_LEN_W:0]              remain_q;
  logic [`RS_LEN_W:0]              remain_init;
  logic                            first_q;
  logic                            fetch_done;

  assign start_off   = base_addr_i[`RS_OFF_W-1:0];
  assign remain_init = {1'b0, line_len_i} + {{`RS_LEN_W{1'b0}}, (start_off != '0)};

  assign mem_req_o  = running_i && fetch_ready_i && (remain_q != '0);
  assign fetch_done = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_addr_q <= '0;
      offset_q    <= '0;
      remain_q    <= '0;
      first_q     <= 1'b0;
    end else if (line_start_i) begin
      word_addr_q <= base_addr_i[`RS_ADDR_W-1:`RS_OFF_W];
      offset_q    <= start_off;
      remain_q    <= remain_init;
      first_q     <= 1'b1;
    end else if (fetch_done) begin
      word_addr_q <= word_addr_q + 1'b1;
      remain_q    <= remain_q - 1'b1;
      first_q     <= 1'b0;
    end
  end

  assign mem_addr_o    = word_addr_q;
  assign offset_o      = offset_q;
  assign fetch_first_o = first_q;
  assign fetch_last_o  = (remain_q == {{`RS_LEN_W{1'b0}}, 1'b1});

endmodule

// File: rtl/src_realign.sv
// realignment datapath with previous-word register and stream handshake
`include "realign_src_params.svh"

module src_realign (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  stream_pkg::byte_off_t offset_i,
  input  logic                  fetch_first_i,
  input  logic                  mem_req_i,
  input  logic                  mem_gnt_i,
  input  stream_pkg::word_t     mem_rdata_i,
  input  logic                  last_word_i,
  input  logic                  out_ready_i,
  output logic                  fetch_ready_o,
  output logic                  out_valid_o,
  output stream_pkg::word_t     out_data_o,
  output logic                  out_last_o,
  output logic                  out_fire_o
);

  stream_pkg::word_t prev_q;
  stream_pkg::word_t prev_part;
  stream_pkg::word_t curr_part;
  logic              misaligned;
  logic              skip_fetch;
  logic              fetch_fire;
  // shift amounts in bits, up to the full word width
  logic [$clog2(`RS_DATA_W):0] shift_dn;
  logic [$clog2(`RS_DATA_W):0] shift_up;

  assign misaligned = (offset_i != '0);
  // first misaligned fetch only primes prev_q
  assign skip_fetch = misaligned && fetch_first_i;
  assign fetch_fire = mem_req_i && mem_gnt_i;

  // the priming fetch is accepted even with the output stalled
  assign fetch_ready_o = out_ready_i || skip_fetch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_q <= '0;
    end else if (fetch_fire) begin
      prev_q <= mem_rdata_i;
    end
  end

  assign shift_dn = {offset_i, 3'b000};
  assign shift_up = `RS_DATA_W - shift_dn;

  // upper bytes of the previous word land in the low lanes
  assign prev_part = prev_q >> shift_dn;
  assign curr_part = mem_rdata_i << shift_up;

  always_comb begin
    if (misaligned) begin
      out_data_o = prev_part | curr_part;
    end else begin
      out_data_o = mem_rdata_i;
    end
  end

  // requests only go out with ready high, so valid never waits on ready
  assign out_valid_o = fetch_fire && !skip_fetch;
  assign out_last_o  = out_valid_o && last_word_i;
  assign out_fire_o  = out_valid_o && out_ready_i;

endmodule

// File: rtl/realign_src_top.sv
// realigning stream source top level with controller, address generator and realigner
`include "realign_src_params.svh"

module realign_src_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cfg_we_i,
  input  src_cfg_pkg::cfg_sel_e           cfg_sel_i,
  input  src_cfg_pkg::cfg_word_u          cfg_wdata_i,
  input  logic                            start_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            mem_req_o,
  output logic [`RS_ADDR_W-`RS_OFF_W-1:0] mem_addr_o,
  input  logic                            mem_gnt_i,
  input  stream_pkg::word_t               mem_rdata_i,
  output logic                            out_valid_o,
  output stream_pkg::word_t               out_data_o,
  output logic                            out_last_o,
  input  logic                            out_ready_i
);

  logic                  line_start;
  logic [`RS_ADDR_W-1:0] base_addr;
  logic [`RS_LEN_W-1:0]  line_len;
  logic                  running;
  logic                  last_word;
  logic                  fetch_first;
  stream_pkg::byte_off_t offset;
  logic                  fetch_ready;
  logic                  out_fire;

  src_ctrl i_src_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .start_i      (start_i),
    .out_fire_i   (out_fire),
    .line_start_o (line_start),
    .base_addr_o  (base_addr),
    .line_len_o   (line_len),
    .running_o    (running),
    .last_word_o  (last_word),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  src_addr_gen i_src_addr_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_start_i  (line_start),
    .base_addr_i   (base_addr),
    .line_len_i    (line_len),
    .running_i     (running),
    .fetch_ready_i (fetch_ready),
    .mem_gnt_i     (mem_gnt_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .fetch_first_o (fetch_first),
    .fetch_last_o  (),
    .offset_o      (offset)
  );

  src_realign i_src_realign (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .offset_i      (offset),
    .fetch_first_i (fetch_first),
    .mem_req_i     (mem_req_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rdata_i   (mem_rdata_i),
    .last_word_i   (last_word),
    .out_ready_i   (out_ready_i),
    .fetch_ready_o (fetch_ready),
    .out_valid_o   (out_valid_o),
    .out_data_o    (out_data_o),
    .out_last_o    (out_last_o),
    .out_fire_o    (out_fire)
  );

endmodule

// File: sim/tb_mem_model.sv
// combinational word memory model with a throttled grant
`include "realign_src_params.svh"

module tb_mem_model (
  input  logic                            req_i,
  input  logic [`RS_ADDR_W-`RS_OFF_W-1:0] addr_i,
  input  logic                            gnt_en_i,
  output logic                            gnt_o,
  output stream_pkg::word_t               rdata_o
);

  localparam int MEM_WORDS = 256;

  // word storage, filled by the testbench before reset is released
  stream_pkg::word_t mem_q [0:MEM_WORDS-1];

  logic [7:0] word_idx;

  // low address bits select the word, the model wraps beyond its size
  assign word_idx = addr_i[7:0];

  // grant in the same cycle as the request when not throttled
  assign gnt_o = req_i && gnt_en_i;

  // read data is valid combinationally, no read latency
  assign rdata_o = mem_q[word_idx];

  // loads one word of the backing store
  task automatic write_word(input int idx, input stream_pkg::word_t data);
    mem_q[idx] = data;
  endtask

endmodule

// File: sim/tb_realign_src.sv
// testbench for the realigning stream source with memory model, checks and timeout
`include "realign_src_params.svh"

module tb_realign_src;

  localparam int LEN_ALIGNED = 8;
  localparam int LEN_SHIFT   = 6;
  localparam int LEN_RANDOM  = 12;
  localparam int LEN_SINGLE  = 1;
  localparam int LEN_BUSY    = 10;
  localparam int LEN_B2B     = 5;
  // every line plus one cycle each, eight times over, plus slack
  localparam int TIMEOUT_CYC = ((LEN_ALIGNED + 1) + 3 * (LEN_SHIFT + 1) + (LEN_RANDOM + 1)
                               + (LEN_SINGLE + 1) + 2 * (LEN_BUSY + 1)
                               + 2 * (LEN_B2B + 1)) * 8 + 200;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            cfg_we_i;
  src_cfg_pkg::cfg_sel_e           cfg_sel_i;
  src_cfg_pkg::cfg_word_u          cfg_wdata_i;
  logic                            start_i;
  logic                            busy_o;
  logic                            done_o;
  logic                            mem_req_o;
  logic [`RS_ADDR_W-`RS_OFF_W-1:0] mem_addr_o;
  logic                            mem_gnt_i;
  stream_pkg::word_t               mem_rdata_i;
  logic                            out_valid_o;
  stream_pkg::word_t               out_data_o;
  logic                            out_last_o;
  logic                            out_ready_i;
  logic                            gnt_en;

  // reference copy of the memory and the throttle pattern
  logic [31:0] ref_mem [0:255];
  logic [1:0]  throttle_pat [0:1023];
  logic        throttle_en;
  logic        use_random;
  int          cycle_cnt;

  // expectation of the running line
  logic [31:0] line_base;
  int          line_len;
  int          out_idx;
  int          fetch_cnt;
  int          exp_fetches;

  // monitor state
  logic        last_fire_q;
  logic        busy_q;
  logic        done_exp;
  logic        exp_last;
  logic [31:0] exp_word;
  logic [29:0] exp_addr;

  realign_src_top i_realign_src_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rdata_i (mem_rdata_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i)
  );

  tb_mem_model i_tb_mem_model (
    .req_i    (mem_req_o),
    .addr_i   (mem_addr_o),
    .gnt_en_i (gnt_en),
    .gnt_o    (mem_gnt_i),
    .rdata_o  (mem_rdata_i)
  );

  always begin
    #50 clk_i = ~clk_i;
  end

  task automatic report_value(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", sig, got, exp);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_msg(input string msg);
    $display("[ERROR] %s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  // little-endian word of the four bytes at base + 4k
  function automatic logic [31:0] expected_word(input logic [31:0] base, input int k);
    logic [31:0] word;
    logic [31:0] byte_addr;
    int          i;
    word = '0;
    for (i = 0; i < 4; i++) begin
      byte_addr = base + 32'(4 * k + i);
      word[8*i +: 8] = ref_mem[byte_addr[9:2]][8*int'(byte_addr[1:0]) +: 8];
    end
    return word;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #10;
  endtask

  task automatic write_base(input logic [31:0] addr);
    cfg_we_i         = 1'b1;
    cfg_sel_i        = src_cfg_pkg::CFG_ADDR;
    cfg_wdata_i.addr = addr;
    tick();
    cfg_we_i = 1'b0;
  endtask

  task automatic write_len(input int len);
    cfg_we_i              = 1'b1;
    cfg_sel_i             = src_cfg_pkg::CFG_GEOM;
    cfg_wdata_i.geom.rsvd = '0;
    cfg_wdata_i.geom.len  = 16'(len);
    tick();
    cfg_we_i = 1'b0;
  endtask

  task automatic set_expect(input logic [31:0] base, input int len);
    line_base   = base;
    line_len    = len;
    out_idx     = 0;
    fetch_cnt   = 0;
    exp_fetches = len + ((base[1:0] != 2'b00) ? 1 : 0);
  endtask

  // start strobe with the config already in place
  task automatic launch(input logic [31:0] base, input int len);
    set_expect(base, len);
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    assert (busy_o) else report_value("busy_o", busy_o, 1);
    if (!throttle_en) begin
      assert (mem_req_o) else report_value("mem_req_o", mem_req_o, 1);
    end
  endtask

  task automatic start_line(input logic [31:0] base, input int len);
    write_base(base);
    write_len(len);
    launch(base, len);
  endtask

  task automatic wait_done();
    while (!done_o) begin
      tick();
    end
  endtask

  task automatic run_line(input logic [31:0] base, input int len);
    start_line(base, len);
    wait_done();
    tick();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYC) begin
      report_msg("timeout, the tests did not finish within the cycle limit");
    end
  end

  // random ready and grant, enabled per test
  always @(posedge clk_i) begin
    use_random = throttle_en;
    #10;
    if (use_random) begin
      out_ready_i = throttle_pat[cycle_cnt % 1024][0];
      gnt_en      = throttle_pat[cycle_cnt % 1024][1];
    end else begin
      out_ready_i = 1'b1;
      gnt_en      = 1'b1;
    end
  end

  // output checks at the falling edge, where all outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      done_exp = last_fire_q;
      assert (done_o == done_exp) else report_value("done_o", done_o, done_exp);
      if (done_o) begin
        assert (!busy_o) else report_value("busy_o", busy_o, 0);
        assert (busy_q) else report_msg("done_o pulsed without a running line before it");
        assert (out_idx == line_len) else report_value("output word count", out_idx, line_len);
        assert (fetch_cnt == exp_fetches) else report_value("fetch count", fetch_cnt, exp_fetches);
      end
      // with ready low only the priming fetch of a misaligned line may go out
      assert (out_ready_i || !mem_req_o || (fetch_cnt == 0 && line_base[1:0] != 2'b00))
        else report_msg("memory request issued while out_ready_i was low");
      assert (out_ready_i || !out_valid_o)
        else report_msg("out_valid_o raised while out_ready_i was low");
      if (mem_req_o && mem_gnt_i) begin
        exp_addr = line_base[31:2] + 30'(fetch_cnt);
        assert (mem_addr_o == exp_addr)
          else report_value("mem_addr_o", 32'(mem_addr_o), 32'(exp_addr));
        fetch_cnt++;
      end
      last_fire_q = 1'b0;
      if (out_valid_o && out_ready_i) begin
        assert (out_idx < line_len) else report_msg("output word beyond the end of the line");
        exp_word = expected_word(line_base, out_idx);
        exp_last = (out_idx == line_len - 1);
        assert (out_data_o == exp_word) else report_value("out_data_o", out_data_o, exp_word);
        assert (out_last_o == exp_last) else report_value("out_last_o", out_last_o, exp_last);
        out_idx++;
        last_fire_q = exp_last;
      end
      busy_q = busy_o;
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_sel_i   = src_cfg_pkg::CFG_ADDR;
    cfg_wdata_i = '0;
    start_i     = 1'b0;
    out_ready_i = 1'b1;
    gnt_en      = 1'b1;
    throttle_en = 1'b0;
    cycle_cnt   = 0;
    last_fire_q = 1'b0;
    busy_q      = 1'b0;
    set_expect(32'h0, 0);

    void'($urandom(32'h4f66_9d04));
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = $urandom;
      i_tb_mem_model.write_word(i, ref_mem[i]);
    end
    for (int i = 0; i < 1024; i++) begin
      throttle_pat[i][0] = (($urandom % 4) != 0);
      throttle_pat[i][1] = (($urandom % 4) != 0);
    end

    repeat (4) @(posedge clk_i);
    #10;
    assert (!busy_o && !done_o && !mem_req_o && !out_valid_o)
      else report_msg("outputs not low during reset");
    rst_ni = 1'b1;
    tick();

    // aligned line at full rate
    run_line(32'h0000_0040, LEN_ALIGNED);

    // each nonzero byte offset
    run_line(32'h0000_0101, LEN_SHIFT);
    run_line(32'h0000_0182, LEN_SHIFT);
    run_line(32'h0000_0203, LEN_SHIFT);

    // random ready and grant on a misaligned line
    throttle_en = 1'b1;
    run_line(32'h0000_0282, LEN_RANDOM);
    throttle_en = 1'b0;
    tick();

    // single word that straddles two memory words
    run_line(32'h0000_0303, LEN_SINGLE);

    // config writes and start while busy
    start_line(32'h0000_0321, LEN_BUSY);
    repeat (3) tick();
    assert (busy_o) else report_msg("line ended before the writes during busy");
    write_base(32'h0000_0010);
    write_len(3);
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    wait_done();
    tick();
    assert (!busy_o) else report_value("busy_o", busy_o, 0);
    // the kept config relaunches the same line
    launch(32'h0000_0321, LEN_BUSY);
    wait_done();
    tick();

    // zero length start is dropped
    write_len(0);
    set_expect(32'h0000_0321, 0);
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    repeat (3) begin
      assert (!busy_o) else report_value("busy_o", busy_o, 0);
      tick();
    end

    // back to back lines, the second starts right after done
    start_line(32'h0000_0381, LEN_B2B);
    wait_done();
    write_base(32'h0000_03a6);
    launch(32'h0000_03a6, LEN_B2B);
    wait_done();
    repeat (2) tick();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: realign_src.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/src_cfg_pkg.sv
rtl/src_ctrl.sv
rtl/src_addr_gen.sv
rtl/src_realign.sv
rtl/realign_src_top.sv
sim/tb_mem_model.sv
sim/tb_realign_src.sv

// File: Makefile
# Verilator build and run of the realigning stream source testbench

VERILATOR ?= verilator
TOP       ?= tb_realign_src
FILELIST  ?= realign_src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := rtl/realign_src_params.svh
SIM_BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
